/* source/game_scan_pkg.sv */
package game_scan_pkg;

    // ==================================================
    // Scan constants
    // ==================================================
    localparam logic [31:0] START_SECTOR = 32'd32270; // First sector of the directory area
    localparam int MAX_SECTORS = 2000;               // Give up after this many sectors
    localparam int SECTOR_BYTES = 512;
    localparam int BYTE_INDEX_W = 10;
    localparam int GAME_SLOTS = 6;                    // GAME0 .. GAME5
    localparam int SLOT_W = 3;
    localparam int ENTRY_LEN = 11;                    // 8.3 name without the dot

    // Controller status code once card init has finished
    localparam logic [4:0] CARD_IDLE_STATUS = 5'd6;

    // Strobe edge -> beat -> hit -> tracker count
    localparam int SCAN_PIPE_DEPTH = 3;

    // ==================================================
    // Controller interface and pipeline payloads
    // ==================================================
    typedef struct packed {
        logic        rd;        // Held until ready drops
        logic [31:0] address;   // SDHC sector number
    } sd_cmd_t;

    typedef struct packed {
        logic       ready;
        logic [4:0] status;
        logic [7:0] dout;
        logic       byte_available; // Rising edge qualifies dout
    } sd_rsp_t;

    typedef struct packed {
        logic                    valid;
        logic [7:0]              data;
        logic [BYTE_INDEX_W-1:0] index; // Position inside the sector
    } byte_beat_t;

    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] slot;
    } entry_hit_t;

    // Directory walk
    typedef enum logic [2:0] {
        WAIT_INIT,
        START_READ,
        READ_SECTOR,
        SCAN_DATA,
        SETTLE,
        NEXT_SECTOR,
        DONE
    } scan_state_e;

endpackage

/* source/sd_byte_capture.sv */
`timescale 1ns/1ps

module sd_byte_capture import game_scan_pkg::*; (
    input  logic       sys_clk,
    input  logic       sd_reset,
    input  logic       sector_open, // High while a sector streams in
    input  sd_rsp_t    sd_rsp,
    output byte_beat_t beat
);

    logic                    avail_d;   // Previous byte_available level
    logic                    avail_rise;
    logic [BYTE_INDEX_W-1:0] byte_pos;  // Next byte's slot in the sector
    logic                    pos_ok;

    // ==================================================
    // Strobe edge detect
    // ==================================================
    assign avail_rise = sd_rsp.byte_available && !avail_d;

    // Anything past the end of a sector is not directory data
    assign pos_ok = byte_pos < BYTE_INDEX_W'(SECTOR_BYTES);

    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            avail_d    <= 1'b0;
            byte_pos   <= '0;
            beat.valid <= 1'b0;
        end else begin
            avail_d    <= sd_rsp.byte_available;
            beat.valid <= 1'b0; // Single cycle pulse

            if (!sector_open) begin
                byte_pos <= '0; // Numbering restarts with every sector
            end else if (avail_rise && pos_ok) begin
                beat.valid <= 1'b1;
                byte_pos   <= byte_pos + 1'b1;
            end
        end
    end

    // Byte value and its position in the sector
    always_ff @(posedge sys_clk) begin
        if (avail_rise) begin
            beat.data  <= sd_rsp.dout;
            beat.index <= byte_pos;
        end
    end

endmodule

/* source/dir_entry_matcher.sv */
`timescale 1ns/1ps

module dir_entry_matcher import game_scan_pkg::*; (
    input  logic       sys_clk,
    input  logic       sd_reset,
    input  byte_beat_t beat,
    output entry_hit_t hit
);

    // Oldest byte in the top lane, newest in [7:0]
    logic [ENTRY_LEN*8-1:0] window;
    logic [ENTRY_LEN*8-1:0] win_next;
    logic [7:0]             digit;
    logic                   name_ok;
    logic                   full;

    // ==================================================
    // Window update
    // ==================================================
    always_comb begin
        if (beat.index == '0) begin
            // Fresh sector, drop whatever the last one left behind
            win_next = {{(ENTRY_LEN-1)*8{1'b0}}, beat.data};
        end else begin
            win_next = {window[(ENTRY_LEN-1)*8-1:0], beat.data};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (beat.valid) begin
            window <= win_next;
        end
    end

    // ==================================================
    // Name compare on the updated window
    // ==================================================
    assign digit = win_next[55:48]; // Fifth character

    assign name_ok = (win_next[87:56] == "GAME") &&
                     (digit >= "0") && (digit <= "5") &&
                     (win_next[47:0] == "   A78");

    // Index 10 means eleven bytes of this sector are in the window
    assign full = beat.index >= BYTE_INDEX_W'(ENTRY_LEN - 1);

    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            hit.valid <= 1'b0;
        end else begin
            hit.valid <= beat.valid && full && name_ok;
        end
    end

    // ASCII '0'..'5' is 0x30..0x35, low bits give the slot
    always_ff @(posedge sys_clk) begin
        if (beat.valid) begin
            hit.slot <= digit[SLOT_W-1:0];
        end
    end

endmodule

/* source/game_tracker.sv */
`timescale 1ns/1ps

module game_tracker import game_scan_pkg::*; (
    input  logic                  sys_clk,
    input  logic                  sd_reset,
    input  entry_hit_t            hit,
    output logic [GAME_SLOTS-1:0] files_found, // One bit per GAMEn.A78
    output logic [SLOT_W-1:0]     file_count   // Distinct slots seen
);

    logic seen_before;

    // ==================================================
    // Slot bookkeeping
    // ==================================================

    // Same name can sit in more than one sector
    assign seen_before = files_found[hit.slot];

    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            files_found <= '0;
            file_count  <= '0;
        end else if (hit.valid) begin
            files_found[hit.slot] <= 1'b1;
            if (!seen_before) begin
                file_count <= file_count + 1'b1; // First sighting only
            end
        end
    end

    // Count and popcount of the mask move together
    // so both settle on the same edge

endmodule

/* source/scan_sequencer.sv */
`timescale 1ns/1ps

module scan_sequencer import game_scan_pkg::*; (
    input  logic              sys_clk,
    input  logic              sd_reset,
    input  sd_rsp_t           sd_rsp,
    input  logic [SLOT_W-1:0] file_count,
    output sd_cmd_t           sd_cmd,
    output logic              sector_open,
    output logic              scan_done
);

    scan_state_e state;
    logic        rd_q;
    logic [31:0] sector_num;   // Sector to request next
    logic [15:0] sector_count; // Ended sectors, aborted ones too
    logic [1:0]  settle_cnt;   // Cycles spent in SETTLE
    logic        card_idle;
    logic        all_found;
    logic        limit_hit;

    // ==================================================
    // Decode helpers
    // ==================================================
    assign card_idle = sd_rsp.ready && (sd_rsp.status == CARD_IDLE_STATUS);
    assign all_found = file_count == SLOT_W'(GAME_SLOTS);
    assign limit_hit = sector_count == 16'(MAX_SECTORS);

    // Address only moves in NEXT_SECTOR, rd is low there
    assign sd_cmd = '{rd: rd_q, address: sector_num};

    assign sector_open = (state == SCAN_DATA);
    assign scan_done   = (state == DONE);

    // ==================================================
    // Sector walk
    // ==================================================
    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            state        <= WAIT_INIT;
            rd_q         <= 1'b0;
            sector_num   <= START_SECTOR;
            sector_count <= '0;
            settle_cnt   <= '0;
        end else begin
            case (state)
                WAIT_INIT: begin
                    if (card_idle) begin // Card init finished
                        state <= START_READ;
                    end
                end

                START_READ: begin
                    rd_q  <= 1'b1; // Request with a stable address
                    state <= READ_SECTOR;
                end

                READ_SECTOR: begin
                    // Controller took the request once ready drops
                    if (!sd_rsp.ready) begin
                        rd_q  <= 1'b0;
                        state <= SCAN_DATA;
                    end
                end

                SCAN_DATA: begin
                    // Ready back high ends the sector, done or aborted
                    if (sd_rsp.ready) begin
                        sector_count <= sector_count + 1'b1;
                        settle_cnt   <= '0;
                        state        <= SETTLE;
                    end
                end

                SETTLE: begin
                    // Let the last byte reach the tracker before deciding
                    if (settle_cnt == 2'(SCAN_PIPE_DEPTH - 1)) begin
                        state <= NEXT_SECTOR;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end

                NEXT_SECTOR: begin
                    if (all_found || limit_hit) begin
                        state <= DONE;
                    end else begin
                        sector_num <= sector_num + 1'b1;
                        state      <= START_READ;
                    end
                end

                DONE: begin
                    state <= DONE; // Held until reset
                end

                default: begin
                    state <= WAIT_INIT;
                end
            endcase
        end
    end

endmodule

/* source/game_scan_top.sv */
`timescale 1ns/1ps

module game_scan_top import game_scan_pkg::*; (
    input  logic                  sys_clk,
    input  logic                  sd_reset,
    input  sd_rsp_t               sd_rsp,      // From the SPI SD controller
    output sd_cmd_t               sd_cmd,      // To the SPI SD controller
    output logic [GAME_SLOTS-1:0] files_found,
    output logic [SLOT_W-1:0]     file_count,
    output logic                  scan_done
);

    // ==================================================
    // Pipeline wiring
    // ==================================================
    logic       sector_open; // Sequencer -> capture
    byte_beat_t beat;        // Capture -> matcher
    entry_hit_t hit;         // Matcher -> tracker

    scan_sequencer u_sequencer (
        .sys_clk     (sys_clk),
        .sd_reset    (sd_reset),
        .sd_rsp      (sd_rsp),
        .file_count  (file_count),  // Feedback for early stop
        .sd_cmd      (sd_cmd),
        .sector_open (sector_open),
        .scan_done   (scan_done)
    );

    sd_byte_capture u_capture (
        .sys_clk     (sys_clk),
        .sd_reset    (sd_reset),
        .sector_open (sector_open),
        .sd_rsp      (sd_rsp),
        .beat        (beat)
    );

    dir_entry_matcher u_matcher (
        .sys_clk  (sys_clk),
        .sd_reset (sd_reset),
        .beat     (beat),
        .hit      (hit)
    );

    game_tracker u_tracker (
        .sys_clk     (sys_clk),
        .sd_reset    (sd_reset),
        .hit         (hit),
        .files_found (files_found),
        .file_count  (file_count)
    );

endmodule

/* bench/game_scan_props.sv */
`timescale 1ns/1ps

module game_scan_props import game_scan_pkg::*; (
    input logic                  sys_clk,
    input logic                  sd_reset,
    input sd_rsp_t               sd_rsp,
    input sd_cmd_t               sd_cmd,
    input logic [GAME_SLOTS-1:0] files_found,
    input logic [SLOT_W-1:0]     file_count,
    input logic                  scan_done
);

    int   fail_count = 0; // Failed properties so far
    logic idle_seen;      // Card reported idle since reset

    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            idle_seen <= 1'b0;
        end else if (sd_rsp.ready && sd_rsp.status == CARD_IDLE_STATUS) begin
            idle_seen <= 1'b1;
        end
    end

    // ==================================================
    // Tracker results
    // ==================================================
    a_count_popcount: assert property (@(posedge sys_clk) disable iff (sd_reset)
        file_count == SLOT_W'($countones(files_found)))
    else begin
        fail_count++;
        $error("file_count differs from the number of found slots");
    end

    a_count_monotonic: assert property (@(posedge sys_clk) disable iff (sd_reset)
        !$past(sd_reset) |-> file_count >= $past(file_count))
    else begin
        fail_count++;
        $error("file_count went down without a reset");
    end

    // ==================================================
    // Controller handshake
    // ==================================================
    a_no_rd_before_idle: assert property (@(posedge sys_clk) disable iff (sd_reset)
        !idle_seen |-> !sd_cmd.rd)
    else begin
        fail_count++;
        $error("read requested before the card reported idle");
    end

    // Controller took the request, drop rd next cycle
    a_rd_release: assert property (@(posedge sys_clk) disable iff (sd_reset)
        (sd_cmd.rd && !sd_rsp.ready) |=> !sd_cmd.rd)
    else begin
        fail_count++;
        $error("rd still high a cycle after ready fell");
    end

    a_done_sticky: assert property (@(posedge sys_clk) disable iff (sd_reset)
        scan_done |=> (scan_done && !sd_cmd.rd))
    else begin
        fail_count++;
        $error("scan_done dropped or a read followed it");
    end

endmodule

bind game_scan_top game_scan_props u_props (
    .sys_clk     (sys_clk),
    .sd_reset    (sd_reset),
    .sd_rsp      (sd_rsp),
    .sd_cmd      (sd_cmd),
    .files_found (files_found),
    .file_count  (file_count),
    .scan_done   (scan_done)
);

/* bench/game_scan_tb.sv */
`timescale 1ns/1ps

module game_scan_tb import game_scan_pkg::*; ();

    localparam int  CLK_NS      = 8;
    localparam real WATCHDOG_NS = 2.0 * MAX_SECTORS * 300.0 * CLK_NS; // Both scans, worst case

    logic                  sys_clk  = 1'b0;
    logic                  sd_reset = 1'b1;
    sd_rsp_t               sd_rsp   = '0; // Controller model outputs
    sd_cmd_t               sd_cmd;
    logic [GAME_SLOTS-1:0] files_found;
    logic [SLOT_W-1:0]     file_count;
    logic                  scan_done;

    logic [31:0] rng_state = 32'he98d;
    logic [7:0]  sec_data [SECTOR_BYTES]; // Bytes of the sector being served
    int          sec_len;                 // Bytes sent before ready rises
    int          reads;                   // Requests served this scan

    game_scan_top UUT (
        .sys_clk     (sys_clk),
        .sd_reset    (sd_reset),
        .sd_rsp      (sd_rsp),
        .sd_cmd      (sd_cmd),
        .files_found (files_found),
        .file_count  (file_count),
        .scan_done   (scan_done)
    );

    always #(CLK_NS / 2) sys_clk = ~sys_clk;

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 8; // Low bits of an LCG repeat quickly
    endfunction

    function automatic logic [7:0] filler_byte();
        logic [7:0] b;
        b = 8'(next_rand());
        return (b == "G") ? 8'h20 : b; // No name can start inside filler
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp) else
            stop_with_failure($sformatf("mismatch %s: expected 0x%0h, got 0x%0h",
                                        name, exp, got));
    endtask

    task automatic plant_name(input int off, input string name);
        for (int i = 0; i < name.len(); i++) begin
            sec_data[off + i] = name[i];
        end
        if (off + name.len() + 3 > sec_len) begin
            sec_len = off + name.len() + 3; // A few trailing filler bytes
        end
    endtask

    // ==================================================
    // Sector contents per scan
    // ==================================================
    task automatic build_sector(input bit full_set, input int s);
        int off;
        for (int i = 0; i < SECTOR_BYTES; i++) begin
            sec_data[i] = filler_byte();
        end
        sec_len = 4 + int'(next_rand() % 16); // Early abort unless planted
        off     = int'(next_rand() % 8);
        if (full_set) begin
            if (s < 3) begin // Two slots per sector
                plant_name(off, $sformatf("GAME%0d   A78", 2 * s));
                plant_name(off + 20, $sformatf("GAME%0d   A78", 2 * s + 1));
            end
        end else begin
            case (s)
                1:  plant_name(off, "GAME0   A78");
                3:  plant_name(off, "GAME2   A78");
                4: begin
                    plant_name(off, "GAME6   A78");      // Digit past slot 5
                    plant_name(off + 20, "GAME3   A79"); // Wrong extension
                end
                6: begin
                    plant_name(SECTOR_BYTES - 6, "GAME1 "); // Head of a split name
                    sec_len = SECTOR_BYTES;
                end
                7:  plant_name(0, "  A78");
                9:  plant_name(off, "GAME2   A78"); // Same slot again
                12: plant_name(off, "GAME5   A78");
                default: ;
            endcase
        end
    endtask

    // SD controller model, called once rd is seen high
    task automatic serve_sector(input bit full_set);
        expect_equal("sd_cmd.address", sd_cmd.address, START_SECTOR + 32'(reads));
        build_sector(full_set, reads);
        repeat (1 + next_rand() % 4) @(negedge sys_clk);
        sd_rsp.ready = 1'b0; // Request accepted
        while (sd_cmd.rd) begin
            @(negedge sys_clk);
        end
        for (int i = 0; i < sec_len; i++) begin
            @(negedge sys_clk);
            sd_rsp.dout           = sec_data[i];
            sd_rsp.byte_available = 1'b1;
            @(negedge sys_clk);
            sd_rsp.byte_available = 1'b0;
            repeat (next_rand() % 3) @(negedge sys_clk);
        end
        @(negedge sys_clk);
        sd_rsp.ready = 1'b1; // Sector over, whole or aborted
        reads++;
    endtask

    task automatic run_scenario(input bit full_set, input logic [31:0] exp_mask,
                                input int exp_count, input int exp_reads);
        @(negedge sys_clk);
        sd_reset = 1'b1;
        sd_rsp   = '0; // Card still initializing
        repeat (16) @(negedge sys_clk);
        sd_reset = 1'b0;
        reads    = 0;
        repeat (8) begin // Quiet until the card is idle
            @(negedge sys_clk);
            expect_equal("sd_cmd.rd", sd_cmd.rd, 0);
            expect_equal("scan_done", scan_done, 0);
            expect_equal("files_found", files_found, 0);
            expect_equal("file_count", file_count, 0);
        end
        sd_rsp.status = CARD_IDLE_STATUS;
        sd_rsp.ready  = 1'b1;
        while (!scan_done) begin
            @(negedge sys_clk);
            if (sd_cmd.rd) begin
                serve_sector(full_set);
            end
        end
        repeat (20) begin
            @(negedge sys_clk);
            expect_equal("sd_cmd.rd", sd_cmd.rd, 0);
        end
        expect_equal("files_found", files_found, exp_mask);
        expect_equal("file_count", file_count, exp_count);
        expect_equal("reads", reads, exp_reads);
    endtask

    // ==================================================
    // Run control
    // ==================================================
    always @(negedge sys_clk) begin
        if (UUT.u_props.fail_count != 0) begin
            stop_with_failure("a bound property assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired before the scans finished");
    end

    initial begin
        run_scenario(1'b0, 32'h25, 3, MAX_SECTORS); // Slots 0, 2, 5
        run_scenario(1'b1, 32'h3f, GAME_SLOTS, 3);  // All slots, early stop
        if (UUT.u_props.fail_count != 0) begin
            stop_with_failure("a bound property assertion failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* game_scan_top.f */
source/game_scan_pkg.sv
source/sd_byte_capture.sv
source/dir_entry_matcher.sv
source/game_tracker.sv
source/scan_sequencer.sv
source/game_scan_top.sv
bench/game_scan_props.sv
bench/game_scan_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the game scan testbench with Verilator, runs it and scans the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module game_scan_tb \
    -f game_scan_top.f -o sim_game_scan \
    && ./obj_dir/sim_game_scan +verilator+error+limit+100 2>&1 | tee sim.log \
    && ! grep -q "Simulation failed" sim.log \
    || exit 1
